// ==== rv_core.f ====
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb
    import rv_pkg::*;
();

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    mask_t dmem_rmask;
    mask_t dmem_wmask;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t prog [0:1023];
    word_t dmem [0:255];
    word_t m_regs [0:31];
    word_t m_mem [0:255];
    word_t m_pc;
    word_t halt_addr;
    word_t out_off;
    int    n_instr;
    logic  built;
    logic  running;

    word_t exp_addr_q [$];
    mask_t exp_mask_q [$];
    word_t exp_data_q [$];
    word_t exp_ld_addr_q [$];
    mask_t exp_ld_mask_q [$];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_rdata = prog[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    rv_core i_rv_core (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_rmask_o (dmem_rmask),
        .dmem_wmask_o (dmem_wmask),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    always @(posedge clk) begin
        for (int l = 0; l < 4; l++) begin
            if (dmem_wmask[l]) begin
                dmem[dmem_addr[9:2]][l*8 +: 8] <= dmem_wdata[l*8 +: 8];
            end
        end
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(string name, mask_t got, mask_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(word_t imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_e op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(word_t imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(word_t imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
    endfunction

    function automatic word_t enc_u(word_t imm, reg_idx_t rd, opcode_e op);
        return {imm[31:12], rd, op};
    endfunction

    function automatic word_t enc_j(word_t imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(word_t w);
        prog[n_instr] = w;
        n_instr++;
    endtask

    // sw into the next free word of the result area
    task automatic save_reg(reg_idx_t r);
        emit(enc_s(out_off, r, 5'd0, 3'b010));
        out_off += 32'd4;
    endtask

    task automatic load_const(reg_idx_t r, word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit(enc_u(hi, r, op_lui));
        emit(enc_i(v, r, 3'b000, r, op_imm));
    endtask

    task automatic build_program();
        word_t      v;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [1:0] kind;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        int         pair_a [3] = '{5, 3, -2};
        int         pair_b [3] = '{5, -2, 3};
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        n_instr = 0;
        out_off = 32'd512;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = NOP_INSTR;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (i < 2) ? $urandom() : word_t'(i) * 32'h9e37_79b9;
            m_mem[i] = dmem[i];
        end
        for (int r = 1; r < 16; r++) begin
            load_const(reg_idx_t'(r), $urandom());
        end
        // random alu, lui and auipc
        for (int k = 0; k < 24; k++) begin
            rd   = reg_idx_t'($urandom_range(15, 1));
            rs1  = reg_idx_t'($urandom_range(15, 0));
            rs2  = reg_idx_t'($urandom_range(15, 0));
            f3   = 3'($urandom_range(7, 0));
            kind = 2'($urandom_range(3, 0));
            v    = $urandom();
            f7   = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, v[31], 5'b0} : 7'b0;
            case (kind)
                2'd0: emit(enc_r(f7, rs2, rs1, f3, rd));
                2'd1: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        v = {20'b0, f7, rs2};
                    end
                    emit(enc_i(v, rs1, f3, rd, op_imm));
                end
                2'd2: emit(enc_u(v, rd, op_lui));
                default: emit(enc_u(v, rd, op_auipc));
            endcase
            save_reg(rd);
        end
        // sb at every byte, sh at every half
        for (int off = 0; off < 4; off++) begin
            load_const(5'd5, $urandom());
            emit(enc_s(out_off + word_t'(off), 5'd5, 5'd0, 3'b000));
            if (off % 2 == 0) begin
                emit(enc_s(out_off + 32'd4 + word_t'(off), 5'd5, 5'd0, 3'b001));
            end
            out_off += 32'd8;
        end
        // every load size at every legal offset and used right away
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int lf = 0; lf < 6; lf++) begin
                    if (lf != 3 && (off % (1 << (lf % 4))) == 0) begin
                        emit(enc_i(word_t'(w * 4 + off), 5'd0, 3'(lf), 5'd6, op_load));
                        save_reg(5'd6);
                    end
                end
            end
        end
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_i(word_t'(pair_a[p]), 5'd0, 3'b000, 5'd6, op_imm));
                emit(enc_i(word_t'(pair_b[p]), 5'd0, 3'b000, 5'd7, op_imm));
                emit(enc_b(32'd8, 5'd7, 5'd6, conds[c]));
                emit(enc_i(32'd1, 5'd8, 3'b000, 5'd8, op_imm));
                save_reg(5'd8);
            end
        end
        emit(enc_j(32'd8, 5'd9));
        emit(enc_i(32'd100, 5'd8, 3'b000, 5'd8, op_imm));
        save_reg(5'd9);
        // odd offset lands 12 bytes past the auipc
        emit(enc_u(32'd0, 5'd10, op_auipc));
        emit(enc_i(32'd13, 5'd10, 3'b000, 5'd11, op_jalr));
        emit(enc_i(32'd100, 5'd8, 3'b000, 5'd8, op_imm));
        save_reg(5'd11);
        save_reg(5'd8);
        // dependent chain
        emit(enc_i($urandom(), 5'd0, 3'b000, 5'd12, op_imm));
        emit(enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd13));
        emit(enc_r(7'h20, 5'd12, 5'd13, 3'b000, 5'd14));
        emit(enc_r(7'h00, 5'd13, 5'd14, 3'b100, 5'd15));
        save_reg(5'd15);
        emit(enc_i(32'd4, 5'd0, 3'b010, 5'd12, op_load));
        emit(enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd13));
        save_reg(5'd13);
        emit(enc_i(out_off, 5'd0, 3'b000, 5'd12, op_imm));
        emit(enc_s(32'd0, 5'd13, 5'd12, 3'b010));
        out_off += 32'd4;
        emit(enc_j(32'd0, 5'd0));
        built = 1'b1;
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // lanes touched by a byte, half or word access
    function automatic mask_t lanes_for(logic [1:0] size, word_t addr);
        case (size)
            2'b00:   return mask_t'(4'b0001 << addr[1:0]);
            2'b01:   return addr[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // runs one instruction on the model state and queues its accesses
    function automatic void exec_one();
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        word_t      addr;
        word_t      raw;
        word_t      next_pc;
        mask_t      m;
        logic [2:0] f3;
        logic       wr;
        ins     = prog[m_pc[11:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        f3      = ins[14:12];
        imm     = {{20{ins[31]}}, ins[31:20]};
        res     = '0;
        wr      = 1'b1;
        next_pc = m_pc + 32'd4;
        case (ins[6:0])
            op_lui:   res = {ins[31:12], 12'b0};
            op_auipc: res = m_pc + {ins[31:12], 12'b0};
            op_jal: begin
                res     = next_pc;
                next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            op_jalr: begin
                res     = next_pc;
                next_pc = (a + imm) & ~32'd1;
            end
            op_br: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            op_load: begin
                addr = a + imm;
                raw  = m_mem[addr[9:2]] >> {addr[1:0], 3'b000};
                exp_ld_addr_q.push_back(addr);
                exp_ld_mask_q.push_back(lanes_for(f3[1:0], addr));
                case (f3)
                    3'b000:  res = {{24{raw[7]}}, raw[7:0]};
                    3'b001:  res = {{16{raw[15]}}, raw[15:0]};
                    3'b100:  res = {24'b0, raw[7:0]};
                    3'b101:  res = {16'b0, raw[15:0]};
                    default: res = raw;
                endcase
            end
            op_store: begin
                wr   = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                m    = lanes_for(f3[1:0], addr);
                raw  = b << {addr[1:0], 3'b000};
                for (int l = 0; l < 4; l++) begin
                    if (m[l]) begin
                        m_mem[addr[9:2]][l*8 +: 8] = raw[l*8 +: 8];
                    end
                end
                exp_addr_q.push_back(addr);
                exp_mask_q.push_back(m);
                exp_data_q.push_back(raw);
            end
            op_imm, op_reg: begin
                if (ins[6:0] == op_imm) begin
                    b = imm;
                end
                // sub only on register ops but sra and srai on both
                res = alu_ref(f3, ins[30] && (ins[5] || f3 == 3'b101), a, b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = res;
        end
        m_pc = next_pc;
    endfunction

    task automatic run_model();
        int steps;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc  = RESET_PC;
        steps = 0;
        while (prog[m_pc[11:2]] != enc_j(32'd0, 5'd0) && steps < 4096) begin
            exec_one();
            steps++;
        end
        if (steps == 4096) begin
            $display("reference model never reached the halt loop");
            stop_run();
        end
        halt_addr = m_pc;
    endtask

    always @(posedge clk) begin
        word_t lanes;
        mask_t exp_mask;
        if (rst_n && dmem_rmask != '0) begin
            if (exp_ld_addr_q.size() == 0) begin
                $display("unexpected load from %h at %0t", dmem_addr, $time);
                stop_run();
            end else begin
                check_word("dmem_addr_o", dmem_addr, exp_ld_addr_q.pop_front());
                check_mask("dmem_rmask_o", dmem_rmask, exp_ld_mask_q.pop_front());
            end
        end
        if (rst_n && dmem_wmask != '0) begin
            if (exp_addr_q.size() == 0) begin
                $display("unexpected store of %h to %h at %0t", dmem_wdata, dmem_addr, $time);
                stop_run();
            end else begin
                exp_mask = exp_mask_q.pop_front();
                lanes = {{8{exp_mask[3]}}, {8{exp_mask[2]}}, {8{exp_mask[1]}}, {8{exp_mask[0]}}};
                check_word("dmem_addr_o", dmem_addr, exp_addr_q.pop_front());
                check_mask("dmem_wmask_o", dmem_wmask, exp_mask);
                check_word("dmem_wdata_o", dmem_wdata & lanes, exp_data_q.pop_front() & lanes);
            end
        end
        if (running && imem_addr == halt_addr && exp_addr_q.size() == 0
                && exp_ld_addr_q.size() == 0) begin
            if (i_rv_core.i_rv_core_chk.fail_count == 0) begin
                $display("TEST OK");
                $finish;
            end else begin
                $display("bound assertions failed %0d times",
                         i_rv_core.i_rv_core_chk.fail_count);
                stop_run();
            end
        end
    end

    initial begin
        wait (built);
        repeat (n_instr * 8 + 16) @(posedge clk);
        $display("watchdog expired after %0d cycles, core hung or accesses missing",
                 n_instr * 8 + 16);
        stop_run();
    end

    initial begin
        rst_n   = 1'b0;
        running = 1'b0;
        built   = 1'b0;
        void'($urandom(32'h779f));
        build_program();
        run_model();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #2;
            check_word("imem_addr_o", imem_addr, RESET_PC);
            check_mask("dmem_rmask_o", dmem_rmask, 4'b0000);
            check_mask("dmem_wmask_o", dmem_wmask, 4'b0000);
        end
        rst_n   = 1'b1;
        running = 1'b1;
        check_word("imem_addr_o", imem_addr, RESET_PC);
    end

endmodule

// ==== tests/rv_core_chk.sv ====
`timescale 1ns/1ps

module rv_core_chk
    import rv_pkg::*;
(
    input logic  clk_i,
    input logic  rst_n_i,
    input word_t imem_addr_o,
    input mask_t dmem_rmask_o,
    input mask_t dmem_wmask_o
);

    int unsigned fail_count = 0;

    function automatic logic legal_lanes(mask_t m);
        return m inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                         4'b0011, 4'b1100, 4'b1111};
    endfunction

    masks_idle_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (dmem_rmask_o == '0 && dmem_wmask_o == '0))
        else begin
            $error("data masks active during reset");
            fail_count++;
        end

    no_read_with_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(dmem_rmask_o != '0 && dmem_wmask_o != '0))
        else begin
            $error("read and write masks active together");
            fail_count++;
        end

    // byte, aligned half or full word only
    legal_mask_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        legal_lanes(dmem_rmask_o) && legal_lanes(dmem_wmask_o))
        else begin
            $error("illegal byte-lane mask");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk_i) imem_addr_o[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

endmodule

bind rv_core rv_core_chk i_rv_core_chk (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .imem_addr_o  (imem_addr_o),
    .dmem_rmask_o (dmem_rmask_o),
    .dmem_wmask_o (dmem_wmask_o)
);

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    output word_t imem_addr_o,
    input  word_t imem_rdata_i,
    output word_t dmem_addr_o,
    output mask_t dmem_rmask_o,
    output mask_t dmem_wmask_o,
    output word_t dmem_wdata_o,
    input  word_t dmem_rdata_i
);

    word_t     pc_q;
    word_t     f_pc_q;
    word_t     f_instr_q;

    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    alu_op_e   alu_op;
    cmp_op_e   cmp_op;
    logic      a_is_pc;
    logic      b_is_imm;
    logic      rd_we;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_load;
    logic      is_store;
    logic      load_unsigned;
    mem_size_e mem_size;
    wb_sel_e   wb_sel;

    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     alu_res;
    word_t     target;
    logic      redirect;

    word_t     m_alu_q;
    word_t     m_pc4_q;
    word_t     m_wdata_q;
    reg_idx_t  m_rd_q;
    logic      m_we_q;
    wb_sel_e   m_wb_sel_q;
    mem_size_e m_size_q;
    logic      m_unsigned_q;
    logic      m_load_q;
    logic      m_store_q;
    word_t     wb_data;

    assign imem_addr_o = pc_q;

    // fetch, a taken transfer squashes the word just fetched
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q      <= RESET_PC;
            f_pc_q    <= RESET_PC;
            f_instr_q <= NOP_INSTR;
        end else begin
            pc_q      <= redirect ? target : pc_q + 32'd4;
            f_pc_q    <= pc_q;
            f_instr_q <= redirect ? NOP_INSTR : imem_rdata_i;
        end
    end

    rv_decode i_rv_decode (
        .instr_i         (f_instr_q),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rd_o            (rd),
        .imm_o           (imm),
        .alu_op_o        (alu_op),
        .cmp_op_o        (cmp_op),
        .a_is_pc_o       (a_is_pc),
        .b_is_imm_o      (b_is_imm),
        .rd_we_o         (rd_we),
        .is_branch_o     (is_branch),
        .is_jal_o        (is_jal),
        .is_jalr_o       (is_jalr),
        .is_load_o       (is_load),
        .is_store_o      (is_store),
        .load_unsigned_o (load_unsigned),
        .mem_size_o      (mem_size),
        .wb_sel_o        (wb_sel)
    );

    rv_regfile i_rv_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (m_we_q),
        .waddr_i  (m_rd_q),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .wdata_i  (wb_data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // forward from the result stage
    assign rs1_val = (m_we_q && m_rd_q != '0 && m_rd_q == rs1) ? wb_data : rf_rdata1;
    assign rs2_val = (m_we_q && m_rd_q != '0 && m_rd_q == rs2) ? wb_data : rf_rdata2;

    rv_execute i_rv_execute (
        .pc_i        (f_pc_q),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .imm_i       (imm),
        .alu_op_i    (alu_op),
        .cmp_op_i    (cmp_op),
        .a_is_pc_i   (a_is_pc),
        .b_is_imm_i  (b_is_imm),
        .is_branch_i (is_branch),
        .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),
        .alu_o       (alu_res),
        .target_o    (target),
        .redirect_o  (redirect)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_alu_q      <= '0;
            m_pc4_q      <= '0;
            m_wdata_q    <= '0;
            m_rd_q       <= '0;
            m_we_q       <= 1'b0;
            m_wb_sel_q   <= wb_alu;
            m_size_q     <= size_byte;
            m_unsigned_q <= 1'b0;
            m_load_q     <= 1'b0;
            m_store_q    <= 1'b0;
        end else begin
            m_alu_q      <= alu_res;
            m_pc4_q      <= f_pc_q + 32'd4;
            m_wdata_q    <= rs2_val;
            m_rd_q       <= rd;
            m_we_q       <= rd_we;
            m_wb_sel_q   <= wb_sel;
            m_size_q     <= mem_size;
            m_unsigned_q <= load_unsigned;
            m_load_q     <= is_load;
            m_store_q    <= is_store;
        end
    end

    rv_result i_rv_result (
        .alu_i           (m_alu_q),
        .pc4_i           (m_pc4_q),
        .store_data_i    (m_wdata_q),
        .is_load_i       (m_load_q),
        .is_store_i      (m_store_q),
        .load_unsigned_i (m_unsigned_q),
        .mem_size_i      (m_size_q),
        .wb_sel_i        (m_wb_sel_q),
        .dmem_rdata_i    (dmem_rdata_i),
        .dmem_addr_o     (dmem_addr_o),
        .dmem_rmask_o    (dmem_rmask_o),
        .dmem_wmask_o    (dmem_wmask_o),
        .dmem_wdata_o    (dmem_wdata_o),
        .wb_data_o       (wb_data)
    );

endmodule

// ==== verilog/rv_result.sv ====
`timescale 1ns/1ps

module rv_result
    import rv_pkg::*;
(
    input  word_t     alu_i,
    input  word_t     pc4_i,
    input  word_t     store_data_i,
    input  logic      is_load_i,
    input  logic      is_store_i,
    input  logic      load_unsigned_i,
    input  mem_size_e mem_size_i,
    input  wb_sel_e   wb_sel_i,
    input  word_t     dmem_rdata_i,
    output word_t     dmem_addr_o,
    output mask_t     dmem_rmask_o,
    output mask_t     dmem_wmask_o,
    output word_t     dmem_wdata_o,
    output word_t     wb_data_o
);

    mask_t lane_mask;
    word_t rdata_shifted;
    word_t load_data;

    assign dmem_addr_o = alu_i;

    always_comb begin
        case (mem_size_i)
            size_byte: lane_mask = mask_t'(4'b0001 << alu_i[1:0]);
            size_half: lane_mask = alu_i[1] ? 4'b1100 : 4'b0011;
            default:   lane_mask = 4'b1111;
        endcase
    end

    assign dmem_rmask_o = is_load_i  ? lane_mask : '0;
    assign dmem_wmask_o = is_store_i ? lane_mask : '0;

    // move store data up to its lane
    always_comb begin
        case (mem_size_i)
            size_byte: dmem_wdata_o = store_data_i << {alu_i[1:0], 3'b000};
            size_half: dmem_wdata_o = store_data_i << {alu_i[1], 4'b0000};
            default:   dmem_wdata_o = store_data_i;
        endcase
    end

    // bring the addressed lane down to bit 0
    assign rdata_shifted = dmem_rdata_i >> {alu_i[1:0], 3'b000};

    always_comb begin
        case (mem_size_i)
            size_byte: begin
                load_data = {{24{~load_unsigned_i & rdata_shifted[7]}}, rdata_shifted[7:0]};
            end
            size_half: begin
                load_data = {{16{~load_unsigned_i & rdata_shifted[15]}},
                             rdata_shifted[15:0]};
            end
            default: load_data = dmem_rdata_i;
        endcase
    end

    always_comb begin
        case (wb_sel_i)
            wb_pc4:  wb_data_o = pc4_i;
            wb_mem:  wb_data_o = load_data;
            default: wb_data_o = alu_i;
        endcase
    end

endmodule

// ==== verilog/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
    import rv_pkg::*;
(
    input  word_t   pc_i,
    input  word_t   rs1_val_i,
    input  word_t   rs2_val_i,
    input  word_t   imm_i,
    input  alu_op_e alu_op_i,
    input  cmp_op_e cmp_op_i,
    input  logic    a_is_pc_i,
    input  logic    b_is_imm_i,
    input  logic    is_branch_i,
    input  logic    is_jal_i,
    input  logic    is_jalr_i,
    output word_t   alu_o,
    output word_t   target_o,
    output logic    redirect_o
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       taken;

    assign op_a  = a_is_pc_i ? pc_i : rs1_val_i;
    assign op_b  = b_is_imm_i ? imm_i : rs2_val_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            alu_add:    alu_o = op_a + op_b;
            alu_sub:    alu_o = op_a - op_b;
            alu_sll:    alu_o = op_a << shamt;
            alu_slt:    alu_o = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_o = {31'b0, op_a < op_b};
            alu_xor:    alu_o = op_a ^ op_b;
            alu_srl:    alu_o = op_a >> shamt;
            alu_sra:    alu_o = $signed(op_a) >>> shamt;
            alu_or:     alu_o = op_a | op_b;
            alu_and:    alu_o = op_a & op_b;
            alu_pass_b: alu_o = op_b;
            default:    alu_o = op_a + op_b;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (cmp_op_i)
            cmp_beq:  taken = rs1_val_i == rs2_val_i;
            cmp_bne:  taken = rs1_val_i != rs2_val_i;
            cmp_blt:  taken = $signed(rs1_val_i) < $signed(rs2_val_i);
            cmp_bge:  taken = $signed(rs1_val_i) >= $signed(rs2_val_i);
            cmp_bltu: taken = rs1_val_i < rs2_val_i;
            cmp_bgeu: taken = rs1_val_i >= rs2_val_i;
            default:  taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    assign target_o = is_jalr_i ? ((rs1_val_i + imm_i) & ~32'd1) : (pc_i + imm_i);

    assign redirect_o = is_jal_i | is_jalr_i | (is_branch_i & taken);

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
    import rv_pkg::*;
(
    input  word_t     instr_i,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    output reg_idx_t  rd_o,
    output word_t     imm_o,
    output alu_op_e   alu_op_o,
    output cmp_op_e   cmp_op_o,
    output logic      a_is_pc_o,
    output logic      b_is_imm_o,
    output logic      rd_we_o,
    output logic      is_branch_o,
    output logic      is_jal_o,
    output logic      is_jalr_o,
    output logic      is_load_o,
    output logic      is_store_o,
    output logic      load_unsigned_o,
    output mem_size_e mem_size_o,
    output wb_sel_e   wb_sel_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;
    alu_op_e    alu_fn;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign j_imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // funct7 bit 5 picks sub only on register ops, sra on both
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = funct7_b5 ? alu_sra : alu_srl;
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    end

    always_comb begin
        imm_o           = i_imm;
        alu_op_o        = alu_add;
        cmp_op_o        = cmp_op_e'(funct3);
        a_is_pc_o       = 1'b0;
        b_is_imm_o      = 1'b1;
        rd_we_o         = 1'b0;
        is_branch_o     = 1'b0;
        is_jal_o        = 1'b0;
        is_jalr_o       = 1'b0;
        is_load_o       = 1'b0;
        is_store_o      = 1'b0;
        load_unsigned_o = funct3[2];
        mem_size_o      = mem_size_e'(funct3[1:0]);
        wb_sel_o        = wb_alu;
        case (opcode)
            op_lui: begin
                imm_o    = u_imm;
                alu_op_o = alu_pass_b;
                rd_we_o  = 1'b1;
            end
            op_auipc: begin
                imm_o     = u_imm;
                a_is_pc_o = 1'b1;
                rd_we_o   = 1'b1;
            end
            op_jal: begin
                imm_o    = j_imm;
                is_jal_o = 1'b1;
                rd_we_o  = 1'b1;
                wb_sel_o = wb_pc4;
            end
            op_jalr: begin
                is_jalr_o = 1'b1;
                rd_we_o   = 1'b1;
                wb_sel_o  = wb_pc4;
            end
            op_br: begin
                imm_o       = b_imm;
                b_is_imm_o  = 1'b0;
                is_branch_o = 1'b1;
            end
            op_load: begin
                is_load_o = 1'b1;
                rd_we_o   = 1'b1;
                wb_sel_o  = wb_mem;
            end
            op_store: begin
                imm_o      = s_imm;
                is_store_o = 1'b1;
            end
            op_imm: begin
                alu_op_o = alu_fn;
                rd_we_o  = 1'b1;
            end
            op_reg: begin
                alu_op_o   = alu_fn;
                b_is_imm_o = 1'b0;
                rd_we_o    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        wb_alu = 2'b00,
        wb_pc4 = 2'b01,
        wb_mem = 2'b10
    } wb_sel_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    localparam word_t RESET_PC  = 32'h4000_0000;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage
